// File: verilog/spi_chk_pkg.sv
package spi_chk_pkg;

	// ============================
	// Internal buses
	// ============================

	typedef struct packed {
		logic       frame_start;
		logic       frame_end;
		logic       sck_edge;    // Either edge of synchronized sck
		logic       byte_valid;
		logic [7:0] rx_byte;
		logic       partial;     // Frame ended with bits pending
	} spi_evt_t;

	typedef struct packed {
		logic       enable;
		logic [7:0] seed;
		logic [7:0] target;
	} chk_cfg_t;

	typedef struct packed {
		logic [7:0] byte_cnt;
		logic [7:0] match_cnt;
		logic       timeout;
	} chk_cnt_t;

	typedef struct packed {
		logic busy;
		logic done_set;
		logic err_set;
	} chk_flag_t;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		RECEIVE = 2'd1,
		DRAIN   = 2'd2
	} fsm_state_t;

	// ============================
	// Register map
	// ============================

	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_TARGET = 8'h04;
	localparam logic [7:0] REG_STATUS = 8'h08;  // Done and error are W1C
	localparam logic [7:0] REG_COUNTS = 8'h0C;

endpackage

// File: verilog/spi_front.sv
`timescale 1ns/1ps

module spi_front #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sck,
	input  logic                  ssel,
	input  logic                  mosi,
	input  logic [7:0]            byte_cnt,
	output logic                  miso,
	output spi_chk_pkg::spi_evt_t evt
);

	logic [SYNC_STAGES-1:0][2:0] sync_q;  // {sck, ssel, mosi}
	logic                        sck_s;
	logic                        ssel_s;
	logic                        mosi_s;
	logic                        sck_d;
	logic                        ssel_d;
	logic                        sck_rise;
	logic                        sck_fall;
	logic                        ssel_active;
	logic [2:0]                  bit_cnt;
	logic [6:0]                  shift_q;
	logic [7:0]                  tx_q;
	logic                        load_q;

	// ============================
	// Synchronizers and edges
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= {SYNC_STAGES{3'b010}};  // ssel idles high
			sck_d  <= 1'b0;
			ssel_d <= 1'b1;
		end else begin
			sync_q[0] <= {sck, ssel, mosi};
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			sck_d  <= sck_s;
			ssel_d <= ssel_s;
		end
	end

	assign {sck_s, ssel_s, mosi_s} = sync_q[SYNC_STAGES-1];
	assign sck_rise    = sck_s & ~sck_d;
	assign sck_fall    = ~sck_s & sck_d;
	assign ssel_active = ~ssel_s;

	// ============================
	// Receive path
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (!ssel_active) begin
			bit_cnt <= '0;
		end else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (ssel_active && sck_rise) begin
			shift_q <= {shift_q[5:0], mosi_s};  // MSB first
		end
	end

	always_comb begin
		evt             = '0;
		evt.frame_start = ssel_d & ~ssel_s;
		evt.frame_end   = ~ssel_d & ssel_s;
		evt.sck_edge    = sck_rise | sck_fall;
		evt.byte_valid  = ssel_active & sck_rise & (bit_cnt == 3'd7);
		evt.rx_byte     = {shift_q, mosi_s};
		evt.partial     = ~ssel_d & ssel_s & (bit_cnt != 3'd0);
	end

	// ============================
	// Transmit path
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_q <= 1'b0;
			tx_q   <= '0;
		end else begin
			load_q <= evt.frame_start | evt.byte_valid;  // Counts settle one cycle later
			if (load_q) begin
				tx_q <= byte_cnt;
			end else if (ssel_active && sck_fall && bit_cnt != 3'd0) begin
				tx_q <= {tx_q[6:0], 1'b0};  // Hold MSB across byte boundary
			end
		end
	end

	assign miso = tx_q[7];

	// Eight rising edges take at least 15 cycles of unbroken frame
	a_byte_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		evt.byte_valid |-> !$past(ssel, SYNC_STAGES) && $past(ssel_active, 14));

endmodule

// File: verilog/frame_fsm.sv
`timescale 1ns/1ps

module frame_fsm (
	input  logic                   clk,
	input  logic                   rst_n,
	input  spi_chk_pkg::spi_evt_t  evt,
	input  spi_chk_pkg::chk_cnt_t  cnt,
	input  spi_chk_pkg::chk_cfg_t  cfg,
	output logic                   clr,
	output logic                   cnt_en,
	output spi_chk_pkg::chk_flag_t flags
);
	import spi_chk_pkg::*;

	fsm_state_t state_q;
	fsm_state_t state_d;
	logic       bad_q;  // Partial or stalled frame
	logic       bad_d;
	logic       done_q;
	logic       done_d;
	logic       err_q;
	logic       err_d;

	always_comb begin
		state_d = state_q;
		bad_d   = bad_q;
		clr     = 1'b0;
		done_d  = 1'b0;
		err_d   = 1'b0;
		case (state_q)
			IDLE: begin
				if (cfg.enable && evt.frame_start) begin
					state_d = RECEIVE;
					clr     = 1'b1;
					bad_d   = 1'b0;
				end
			end
			RECEIVE: begin
				if (evt.frame_end || cnt.timeout) begin
					state_d = DRAIN;
					bad_d   = evt.partial | cnt.timeout;
				end
			end
			DRAIN: begin
				state_d = IDLE;
				err_d   = bad_q;
				done_d  = !bad_q && (cnt.match_cnt == cfg.target);
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			bad_q   <= 1'b0;
			done_q  <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			bad_q   <= bad_d;
			done_q  <= done_d;
			err_q   <= err_d;
		end
	end

	assign cnt_en         = (state_q == RECEIVE);
	assign flags.busy     = (state_q != IDLE);
	assign flags.done_set = done_q;
	assign flags.err_set  = err_q;

	// Result lands two cycles after the event that ended the frame
	a_err_cause: assert property (@(posedge clk) disable iff (!rst_n)
		err_q |-> $past(evt.partial || cnt.timeout, 2));

	a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
		done_q |-> $past(evt.frame_end && !evt.partial && !cnt.timeout, 2));

endmodule

// File: verilog/frame_counter.sv
`timescale 1ns/1ps

module frame_counter #(
	parameter int TIMEOUT_CYCLES = 64
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clr,
	input  logic                  cnt_en,
	input  spi_chk_pkg::spi_evt_t evt,
	input  spi_chk_pkg::chk_cfg_t cfg,
	output spi_chk_pkg::chk_cnt_t cnt
);

	localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

	logic [7:0]    byte_q;
	logic [7:0]    match_q;
	logic [TW-1:0] idle_q;
	logic [7:0]    expect_byte;
	logic          idle_full;

	assign expect_byte = cfg.seed + byte_q;  // Wraps mod 256
	assign idle_full   = (idle_q == TW'(TIMEOUT_CYCLES));

	// ============================
	// Byte and match counters
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_q  <= '0;
			match_q <= '0;
		end else if (clr) begin
			byte_q  <= '0;
			match_q <= '0;
		end else if (cnt_en && evt.byte_valid) begin
			byte_q <= byte_q + 8'd1;
			if (evt.rx_byte == expect_byte) begin
				match_q <= match_q + 8'd1;
			end
		end
	end

	// ============================
	// sck idle timer
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idle_q <= '0;
		end else if (clr || evt.sck_edge) begin
			idle_q <= '0;
		end else if (cnt_en && !idle_full) begin
			idle_q <= idle_q + TW'(1);  // Saturates at the limit
		end
	end

	assign cnt.byte_cnt  = byte_q;
	assign cnt.match_cnt = match_q;
	assign cnt.timeout   = cnt_en & idle_full;

endmodule

// File: verilog/apb_regs.sv
`timescale 1ns/1ps

module apb_regs #(
	parameter int ADDR_W = 4
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [ADDR_W-1:0]      paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output spi_chk_pkg::chk_cfg_t  cfg,
	input  spi_chk_pkg::chk_cnt_t  cnt,
	input  spi_chk_pkg::chk_flag_t flags
);
	import spi_chk_pkg::*;

	logic       access;
	logic       wr_ctrl;
	logic       wr_target;
	logic       wr_status;
	logic       mapped;
	logic       enable_q;
	logic [7:0] seed_q;
	logic [7:0] target_q;
	logic       done_q;
	logic       err_q;

	assign access    = psel & penable;  // Access phase, no wait states
	assign wr_ctrl   = access & pwrite & (paddr == ADDR_W'(REG_CTRL));
	assign wr_target = access & pwrite & (paddr == ADDR_W'(REG_TARGET));
	assign wr_status = access & pwrite & (paddr == ADDR_W'(REG_STATUS));

	// ============================
	// Control registers
	// ============================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable_q <= 1'b0;
			seed_q   <= '0;
			target_q <= '0;
		end else begin
			if (wr_ctrl) begin
				enable_q <= pwdata[0];
				seed_q   <= pwdata[15:8];
			end
			if (wr_target) begin
				target_q <= pwdata[7:0];
			end
		end
	end

	// New results win over a clear in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done_q <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			if (flags.done_set) begin
				done_q <= 1'b1;
			end else if (wr_status && pwdata[0]) begin
				done_q <= 1'b0;
			end
			if (flags.err_set) begin
				err_q <= 1'b1;
			end else if (wr_status && pwdata[1]) begin
				err_q <= 1'b0;
			end
		end
	end

	// ============================
	// Read decode
	// ============================

	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		case (paddr)
			ADDR_W'(REG_CTRL):   prdata = {16'h0, seed_q, 7'h0, enable_q};
			ADDR_W'(REG_TARGET): prdata = {24'h0, target_q};
			ADDR_W'(REG_STATUS): prdata = {29'h0, flags.busy, err_q, done_q};
			ADDR_W'(REG_COUNTS): prdata = {16'h0, cnt.match_cnt, cnt.byte_cnt};
			default:             mapped = 1'b0;
		endcase
	end

	assign pready  = 1'b1;
	assign pslverr = access & ~mapped;

	assign cfg.enable = enable_q;
	assign cfg.seed   = seed_q;
	assign cfg.target = target_q;

endmodule

// File: verilog/spi_link_checker.sv
`timescale 1ns/1ps

module spi_link_checker #(
	parameter int TIMEOUT_CYCLES = 64,
	parameter int SYNC_STAGES    = 2,
	parameter int ADDR_W         = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sck,
	input  logic              ssel,     // Active low
	input  logic              mosi,
	output logic              miso,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr
);
	import spi_chk_pkg::*;

	spi_evt_t  evt;
	chk_cnt_t  cnt;
	chk_cfg_t  cfg;
	chk_flag_t flags;
	logic      clr;
	logic      cnt_en;

	spi_front #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_front (
		.clk     (clk),
		.rst_n   (rst_n),
		.sck     (sck),
		.ssel    (ssel),
		.mosi    (mosi),
		.byte_cnt(cnt.byte_cnt),  // Echo of the running byte index
		.miso    (miso),
		.evt     (evt)
	);

	frame_fsm u_fsm (
		.clk   (clk),
		.rst_n (rst_n),
		.evt   (evt),
		.cnt   (cnt),
		.cfg   (cfg),
		.clr   (clr),
		.cnt_en(cnt_en),
		.flags (flags)
	);

	frame_counter #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.clr   (clr),
		.cnt_en(cnt_en),
		.evt   (evt),
		.cfg   (cfg),
		.cnt   (cnt)
	);

	apb_regs #(
		.ADDR_W(ADDR_W)
	) u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr),
		.cfg    (cfg),
		.cnt    (cnt),
		.flags  (flags)
	);

endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ============================
// Compare tasks
// ============================

task automatic check_status(input spi_chk_pkg::chk_flag_t got,
		input spi_chk_pkg::chk_flag_t exp);
	if (got !== exp) begin
		$display("mismatch status got=%h exp=%h", got, exp);
		err_cnt++;
	end
endtask

task automatic check_counts(input spi_chk_pkg::chk_cnt_t got,
		input spi_chk_pkg::chk_cnt_t exp);
	if (got !== exp) begin
		$display("mismatch counts got=%h exp=%h", got, exp);
		err_cnt++;
	end
endtask

task automatic check_miso_byte(input int idx, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("mismatch miso[%0d] got=%h exp=%h", idx, got, exp);
		err_cnt++;
	end
endtask

// ============================
// APB accesses
// ============================

task automatic check_pready();
	if (pready !== 1'b1) begin
		$display("pready was low in an access phase");
		err_cnt++;
	end
endtask

task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
	@(posedge clk);
	#1;
	psel    = 1'b1;
	pwrite  = 1'b1;
	paddr   = addr;
	pwdata  = data;
	@(posedge clk);
	#1;
	penable = 1'b1;
	@(posedge clk);
	check_pready();
	#1;
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
	@(posedge clk);
	#1;
	psel    = 1'b1;
	pwrite  = 1'b0;
	paddr   = addr;
	@(posedge clk);
	#1;
	penable = 1'b1;
	@(posedge clk);
	data    = prdata;  // Sampled in the access phase
	err     = pslverr;
	check_pready();
	#1;
	psel    = 1'b0;
	penable = 1'b0;
endtask

// Mode 0 host, four clocks per sck phase
task automatic spi_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
	int i;
	rx = '0;
	for (i = 7; i > 7 - nbits; i--) begin
		mosi = tx[i];
		repeat (4) @(posedge clk);
		#1;
		rx[i] = miso;
		sck   = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		sck   = 1'b0;
	end
endtask

`endif

// File: verification/tb_spi_link_checker.sv
`timescale 1ns/1ps

module tb_spi_link_checker;
	import spi_chk_pkg::*;

	typedef logic [7:0] byte_q_t[$];

	localparam int TIMEOUT_CYCLES = 64;
	localparam int MAX_BYTES      = 20;
	localparam int N_FRAMES       = 13;  // Frames sent over all tests
	localparam int CYCLE_LIMIT    = N_FRAMES * MAX_BYTES * 8 * 8 + 20000;

	logic        clk;
	logic        rst_n;
	logic        sck;
	logic        ssel;
	logic        mosi;
	logic        miso;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int err_cnt;
	int test_cnt;
	int fail_cnt;
	int cycle_cnt;

	// Reference model state
	logic [7:0] mdl_bytes;
	logic [7:0] mdl_match;
	logic       mdl_done;
	logic       mdl_err;

	`include "tb_checks.svh"

	spi_link_checker #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES),
		.SYNC_STAGES   (2),
		.ADDR_W        (4)
	) u_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.sck    (sck),
		.ssel   (ssel),
		.mosi   (mosi),
		.miso   (miso),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped at %0d cycles before the tests finished", cycle_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	// ============================
	// Helpers
	// ============================

	task automatic check_config(input chk_cfg_t got, input chk_cfg_t exp);
		if (got !== exp) begin
			$display("mismatch config got=%h exp=%h", got, exp);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	task automatic read_flags(output chk_flag_t f);
		logic [31:0] rd;
		logic        perr;
		apb_read(4'(REG_STATUS), rd, perr);
		f.busy     = rd[2];
		f.done_set = rd[0];
		f.err_set  = rd[1];
	endtask

	task automatic wait_idle();
		chk_flag_t f;
		f.busy = 1'b1;
		while (f.busy) begin
			read_flags(f);
		end
	endtask

	task automatic configure(input logic en, input logic [7:0] seed, input logic [7:0] target);
		apb_write(4'(REG_CTRL), {16'h0, seed, 7'h0, en});
		apb_write(4'(REG_TARGET), {24'h0, target});
	endtask

	task automatic clear_status();
		apb_write(4'(REG_STATUS), 32'h3);
		mdl_done = 1'b0;
		mdl_err  = 1'b0;
	endtask

	function automatic int count_matches(input logic [7:0] seed, input byte_q_t data);
		int m;
		m = 0;
		foreach (data[i]) begin
			if (data[i] == seed + 8'(i)) begin
				m++;
			end
		end
		return m;
	endfunction

	task automatic model_frame(input logic [7:0] seed, input logic [7:0] target,
			input byte_q_t data, input bit bad);
		int m;
		m         = count_matches(seed, data);
		mdl_bytes = 8'(data.size());
		mdl_match = 8'(m);
		if (bad) begin
			mdl_err = 1'b1;
		end else if (8'(m) == target) begin
			mdl_done = 1'b1;
		end
	endtask

	task automatic check_against_model();
		chk_flag_t   got_f;
		chk_flag_t   exp_f;
		chk_cnt_t    got_c;
		chk_cnt_t    exp_c;
		logic [31:0] rd;
		logic        perr;
		read_flags(got_f);
		exp_f.busy     = 1'b0;
		exp_f.done_set = mdl_done;
		exp_f.err_set  = mdl_err;
		check_status(got_f, exp_f);
		apb_read(4'(REG_COUNTS), rd, perr);
		got_c.byte_cnt  = rd[7:0];
		got_c.match_cnt = rd[15:8];
		got_c.timeout   = 1'b0;  // Not visible on the bus
		exp_c.byte_cnt  = mdl_bytes;
		exp_c.match_cnt = mdl_match;
		exp_c.timeout   = 1'b0;
		check_counts(got_c, exp_c);
	endtask

	// Whole bytes, then an optional cut byte or a stalled sck
	task automatic send_frame(input byte_q_t data, input int tail_bits, input bit stall,
			input bit chk_miso);
		logic [7:0] rx;
		int         i;
		@(posedge clk);
		#1;
		ssel = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		for (i = 0; i < data.size(); i++) begin
			spi_byte(data[i], 8, rx);
			if (chk_miso) begin
				check_miso_byte(i, rx, 8'(i));
			end
		end
		if (tail_bits > 0) begin
			spi_byte(8'hA5, tail_bits, rx);
		end
		if (stall) begin
			repeat (TIMEOUT_CYCLES + 16) @(posedge clk);
		end
		repeat (4) @(posedge clk);
		#1;
		ssel = 1'b1;
	endtask

	function automatic byte_q_t make_frame(input logic [7:0] seed, input int len,
			input int flip_pct);
		byte_q_t    q;
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = seed + 8'(i);
			if ($urandom_range(99, 0) < flip_pct) begin
				b = b ^ 8'($urandom_range(255, 1));  // Never zero, so always wrong
			end
			q.push_back(b);
		end
		return q;
	endfunction

	// ============================
	// Test sequence
	// ============================

	initial begin
		logic [31:0] rd_ctrl;
		logic [31:0] rd_tgt;
		logic        perr;
		logic [3:0]  bad_addr;
		logic [7:0]  seed;
		logic [7:0]  target;
		chk_cfg_t    got_cfg;
		chk_cfg_t    exp_cfg;
		byte_q_t     data;
		int          len;
		int          m;
		int          errs;

		void'($urandom(64));
		err_cnt   = 0;
		test_cnt  = 0;
		fail_cnt  = 0;
		cycle_cnt = 0;
		rst_n     = 1'b0;
		sck       = 1'b0;
		ssel      = 1'b1;
		mosi      = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		mdl_bytes = '0;
		mdl_match = '0;
		mdl_done  = 1'b0;
		mdl_err   = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Register readback and decode
		errs = err_cnt;
		if (miso !== 1'b0) begin
			$display("miso is not low after reset");
			err_cnt++;
		end
		check_against_model();
		repeat (4) begin
			exp_cfg.enable = 1'($urandom);
			exp_cfg.seed   = 8'($urandom);
			exp_cfg.target = 8'($urandom);
			configure(exp_cfg.enable, exp_cfg.seed, exp_cfg.target);
			apb_read(4'(REG_CTRL), rd_ctrl, perr);
			if (perr) begin
				$display("pslverr raised on a read of CTRL");
				err_cnt++;
			end
			apb_read(4'(REG_TARGET), rd_tgt, perr);
			got_cfg.enable = rd_ctrl[0];
			got_cfg.seed   = rd_ctrl[15:8];
			got_cfg.target = rd_tgt[7:0];
			check_config(got_cfg, exp_cfg);
			bad_addr = {2'($urandom), 2'($urandom_range(3, 1))};
			apb_read(bad_addr, rd_ctrl, perr);
			if (perr !== 1'b1) begin
				$display("no pslverr on a read of unmapped offset %h", bad_addr);
				err_cnt++;
			end
		end
		report_test("apb_readback", errs);

		errs = err_cnt;
		repeat (4) begin
			seed   = 8'($urandom);
			len    = $urandom_range(MAX_BYTES, 1);
			target = $urandom_range(1, 0) ? 8'(len) : 8'(len + $urandom_range(5, 1));
			data   = make_frame(seed, len, 0);
			clear_status();
			configure(1'b1, seed, target);
			send_frame(data, 0, 1'b0, 1'b1);
			model_frame(seed, target, data, 1'b0);
			wait_idle();
			check_against_model();
		end
		report_test("clean_frames_miso", errs);

		errs = err_cnt;
		repeat (4) begin
			seed   = 8'($urandom);
			len    = $urandom_range(MAX_BYTES, 1);
			data   = make_frame(seed, len, 30);
			m      = count_matches(seed, data);
			target = $urandom_range(1, 0) ? 8'(m) : 8'(m + 1);
			clear_status();
			configure(1'b1, seed, target);
			send_frame(data, 0, 1'b0, 1'b1);
			model_frame(seed, target, data, 1'b0);
			wait_idle();
			check_against_model();
		end
		report_test("corrupted_bytes", errs);

		errs = err_cnt;
		seed = 8'($urandom);
		data = make_frame(seed, 3, 0);
		clear_status();
		configure(1'b1, seed, 8'd3);
		send_frame(data, 0, 1'b0, 1'b1);
		model_frame(seed, 8'd3, data, 1'b0);
		wait_idle();
		check_against_model();
		data = make_frame(seed, $urandom_range(3, 1), 0);
		send_frame(data, $urandom_range(7, 3), 1'b0, 1'b1);  // Cut mid-byte
		model_frame(seed, 8'd3, data, 1'b1);
		wait_idle();
		check_against_model();
		clear_status();
		check_against_model();
		data = make_frame(seed, $urandom_range(4, 1), 0);
		send_frame(data, 0, 1'b1, 1'b1);
		model_frame(seed, 8'd3, data, 1'b1);
		wait_idle();
		check_against_model();
		clear_status();
		check_against_model();
		report_test("partial_and_timeout", errs);

		errs = err_cnt;
		seed = 8'($urandom);
		data = make_frame(seed, 2, 0);
		configure(1'b1, seed, 8'd2);
		send_frame(data, 4, 1'b0, 1'b1);
		model_frame(seed, 8'd2, data, 1'b1);
		wait_idle();
		check_against_model();
		len  = $urandom_range(MAX_BYTES, 1);
		data = make_frame(seed, len, 0);
		configure(1'b0, seed, 8'(len));
		send_frame(data, 0, 1'b0, 1'b0);  // Model left untouched
		repeat (8) @(posedge clk);
		wait_idle();
		check_against_model();
		report_test("disabled_frames", errs);

		$display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: spi_link_checker.f
+incdir+include
verilog/spi_chk_pkg.sv
verilog/spi_front.sv
verilog/frame_fsm.sv
verilog/frame_counter.sv
verilog/apb_regs.sv
verilog/spi_link_checker.sv
verification/tb_spi_link_checker.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_spi_link_checker
FILELIST  = spi_link_checker.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
